//--- logic/mem_edge_pkg.sv
// Shared widths, vector types and request structs for the memory edge; modules import it whole
package mem_edge_pkg;

    // ========================================================================
    // Widths and sizes
    // ========================================================================

    // Line address and one beat of line data
    localparam int CL_ADDR_WIDTH = 32;
    localparam int CL_DATA_WIDTH = 64;

    // Request tag carried through memory and echoed on the response
    localparam int MDATA_WIDTH = 16;

    // Multi-line packets hold up to four beats, so a beat number fits in two bits
    localparam int MAX_BEATS = 4;
    localparam int CL_NUM_WIDTH = 2;

    // Write-data heap slots, one per packet in flight
    localparam int HEAP_ENTRIES = 8;
    localparam int HEAP_IDX_WIDTH = 3;

    // The heap address is a slot index with the beat number appended below it
    localparam int HEAP_ADDR_WIDTH = HEAP_IDX_WIDTH + CL_NUM_WIDTH;

    // The client write edge backs off when fewer than this many slots are free
    localparam int HEAP_LOW_WATER = 2;

    // Tag bit reserved for page-table walker reads, clients keep it at zero
    localparam int PT_MDATA_BIT = 15;

    // Header FIFO sizing, with a little slack above the almost-full level
    localparam int TX_ALM_FULL_THRESHOLD = 2;
    localparam int HDR_FIFO_DEPTH = TX_ALM_FULL_THRESHOLD + 2;

    // ========================================================================
    // Types
    // ========================================================================

    typedef logic [CL_ADDR_WIDTH-1:0] cl_addr_t;
    typedef logic [CL_DATA_WIDTH-1:0] cl_data_t;
    typedef logic [MDATA_WIDTH-1:0] mdata_t;

    // Beat number, and also the length field which holds beats minus one
    typedef logic [CL_NUM_WIDTH-1:0] cl_num_t;
    typedef logic [HEAP_IDX_WIDTH-1:0] heap_idx_t;

    // Read request on channel 0
    typedef struct packed {
        logic valid;
        cl_addr_t addr;
        mdata_t mdata;
    } c0_req_t;

    // Read response on channel 0
    typedef struct packed {
        logic valid;
        mdata_t mdata;
        cl_data_t data;
    } c0_rsp_t;

    // Write beat on channel 1, or a packet header whose low data bits hold the heap index
    typedef struct packed {
        logic valid;
        logic sop;
        cl_addr_t addr;
        cl_num_t cl_len;
        mdata_t mdata;
        cl_data_t data;
    } c1_req_t;

endpackage

//--- logic/write_heap_ram.sv
// Write-data heap storage, written by the client write edge and read back by the host edge
`timescale 1ns/10ps

module write_heap_ram
    import mem_edge_pkg::*;
(
    input  logic clk,

    // Write port, addressed by heap index and beat number
    input  logic wen,
    input  logic [HEAP_ADDR_WIDTH-1:0] waddr,
    input  cl_data_t wdata,

    // Read port with one registered stage
    input  logic [HEAP_ADDR_WIDTH-1:0] raddr,
    output cl_data_t rdata
);

    // One entry per beat of every heap slot
    cl_data_t mem [HEAP_ENTRIES*MAX_BEATS];

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end

        // Data shows up the clock after the address
        // A same-cycle write to the read address returns the old contents
        rdata <= mem[raddr];
    end

endmodule

//--- logic/req_fifo.sv
// Small register FIFO for write headers, with a view of the oldest entry and almost-full
`timescale 1ns/10ps

module req_fifo
    import mem_edge_pkg::*;
#(
    parameter int DEPTH = 4,
    parameter int THRESHOLD = 2
)
(
    input  logic clk,
    input  logic reset,

    input  logic enq_en,
    input  c1_req_t enq_data,

    input  logic deq_en,
    output c1_req_t first,
    output logic not_empty,
    output logic alm_full
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    c1_req_t entries [DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;

    // Pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (int'(ptr) == DEPTH - 1)
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (deq_en)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_WIDTH'(enq_en) - CNT_WIDTH'(deq_en);
        end

        if (enq_en)
        begin
            entries[wr_ptr] <= enq_data;
        end
    end

    assign first = entries[rd_ptr];
    assign not_empty = (count != '0);

    // Raised once the free slots drop to the threshold, leaving room for in-flight headers
    assign alm_full = (DEPTH - int'(count)) <= THRESHOLD;

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        enq_en |-> (int'(count) < DEPTH))
        else $error("Header FIFO enqueue while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        deq_en |-> not_empty)
        else $error("Header FIFO dequeue while empty");

endmodule

//--- logic/afu_write_edge.sv
// Client-side write edge that parks beat data in the heap and forwards one header per packet
`timescale 1ns/10ps

module afu_write_edge
    import mem_edge_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  c1_req_t afu_c1_tx,
    output logic afu_c1_alm_full,

    // Header path into the host edge
    input  logic hdr_alm_full,
    output logic hdr_enq_en,
    output c1_req_t hdr_enq,

    // Heap write port
    output logic heap_wen,
    output logic [HEAP_ADDR_WIDTH-1:0] heap_waddr,
    output cl_data_t heap_wdata,

    // Slot release from the host edge once a packet has left
    input  logic heap_free,
    input  heap_idx_t heap_free_idx
);

    logic [HEAP_ENTRIES-1:0] heap_busy;
    heap_idx_t alloc_idx;
    logic [HEAP_IDX_WIDTH:0] free_cnt;

    // Lowest free slot and the number of free slots, both from the busy mask
    always_comb
    begin
        alloc_idx = '0;
        free_cnt = '0;
        for (int i = HEAP_ENTRIES - 1; i >= 0; i--)
        begin
            if (!heap_busy[i])
            begin
                alloc_idx = heap_idx_t'(i);
                free_cnt = free_cnt + 1'b1;
            end
        end
    end

    assign afu_c1_alm_full = hdr_alm_full || (int'(free_cnt) < HEAP_LOW_WATER);

    // ========================================================================
    // Packet tracking
    // ========================================================================

    logic sop_beat;
    logic last_beat;
    heap_idx_t pkt_idx;
    cl_num_t beat_cnt;
    c1_req_t pkt_hdr;

    heap_idx_t cur_idx;
    cl_num_t cur_beat;
    c1_req_t cur_hdr;

    // The sop beat supplies its own header and index, later beats use the held copies
    always_comb
    begin
        sop_beat = afu_c1_tx.valid && afu_c1_tx.sop;
        cur_idx = sop_beat ? alloc_idx : pkt_idx;
        cur_beat = sop_beat ? cl_num_t'(0) : beat_cnt;
        cur_hdr = sop_beat ? afu_c1_tx : pkt_hdr;
        last_beat = afu_c1_tx.valid && (cur_beat == cur_hdr.cl_len);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            heap_busy <= '0;
            beat_cnt <= '0;
            hdr_enq_en <= 1'b0;
        end
        else
        begin
            if (heap_free)
            begin
                heap_busy[heap_free_idx] <= 1'b0;
            end
            if (sop_beat)
            begin
                heap_busy[alloc_idx] <= 1'b1;
            end
            if (afu_c1_tx.valid)
            begin
                beat_cnt <= cur_beat + 1'b1;
            end

            // The header goes out the cycle after the last beat
            hdr_enq_en <= last_beat;
        end

        if (sop_beat)
        begin
            pkt_idx <= alloc_idx;
            pkt_hdr <= afu_c1_tx;
        end

        // Header carries the slot index where the data would be
        if (last_beat)
        begin
            hdr_enq <= cur_hdr;
            hdr_enq.valid <= 1'b1;
            hdr_enq.sop <= 1'b1;
            hdr_enq.data <= cl_data_t'(cur_idx);
        end
    end

    // Every beat lands in the heap at its slot and beat number
    assign heap_wen = afu_c1_tx.valid;
    assign heap_waddr = {cur_idx, cur_beat};
    assign heap_wdata = afu_c1_tx.data;

    a_free_busy: assert property (@(posedge clk) disable iff (reset)
        heap_free |-> heap_busy[heap_free_idx])
        else $error("Heap slot %0d freed while not busy", heap_free_idx);

    a_sop_has_slot: assert property (@(posedge clk) disable iff (reset)
        sop_beat |-> (free_cnt != '0))
        else $error("Write packet started with no free heap slot");

endmodule

//--- logic/fiu_edge.sv
// Host-side edge that injects walker reads, steers responses and rebuilds write beats from the heap
`timescale 1ns/10ps

module fiu_edge
    import mem_edge_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // Client read channel
    input  c0_req_t afu_c0_tx,
    output c0_rsp_t afu_c0_rx,
    output logic afu_c0_alm_full,

    // Page-table walker
    input  logic pt_read_en,
    input  cl_addr_t pt_read_addr,
    output logic pt_read_rdy,
    output logic pt_rsp_en,
    output cl_data_t pt_rsp_data,

    // Write headers from the client write edge
    input  logic hdr_enq_en,
    input  c1_req_t hdr_enq,
    output logic hdr_alm_full,

    // Heap read port and slot release
    output logic [HEAP_ADDR_WIDTH-1:0] heap_raddr,
    input  cl_data_t heap_rdata,
    output logic heap_free,
    output heap_idx_t heap_free_idx,

    // Memory side
    output c0_req_t mem_c0_tx,
    input  c0_rsp_t mem_c0_rx,
    input  logic mem_c0_alm_full,
    output c1_req_t mem_c1_tx,
    input  logic mem_c1_alm_full
);

    // ========================================================================
    // Read channel
    // ========================================================================

    logic pt_req;
    logic pt_emit;
    cl_addr_t pt_addr;
    c0_req_t pt_hdr;
    logic is_pt_rsp;

    assign pt_read_rdy = !pt_req;
    assign afu_c0_alm_full = mem_c0_alm_full;

    // The walker read takes the first slot the client leaves empty
    assign pt_emit = pt_req && !afu_c0_tx.valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pt_req <= 1'b0;
        end
        else
        begin
            pt_req <= (pt_req && !pt_emit) || pt_read_en;
        end

        if (pt_read_en)
        begin
            pt_addr <= pt_read_addr;
        end
    end

    // Walker reads are tagged with only the reserved bit
    always_comb
    begin
        pt_hdr.valid = 1'b1;
        pt_hdr.addr = pt_addr;
        pt_hdr.mdata = '0;
        pt_hdr.mdata[PT_MDATA_BIT] = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_c0_tx.valid <= 1'b0;
        end
        else if (pt_emit)
        begin
            mem_c0_tx <= pt_hdr;
        end
        else
        begin
            mem_c0_tx <= afu_c0_tx;
        end
    end

    // Responses with the reserved bit go to the walker and nowhere else
    always_comb
    begin
        is_pt_rsp = mem_c0_rx.mdata[PT_MDATA_BIT];
        pt_rsp_en = mem_c0_rx.valid && is_pt_rsp;
        pt_rsp_data = mem_c0_rx.data;
        afu_c0_rx = mem_c0_rx;
        afu_c0_rx.valid = mem_c0_rx.valid && !is_pt_rsp;
    end

    // ========================================================================
    // Write channel
    // ========================================================================

    c1_req_t hdr_first;
    logic hdr_not_empty;
    logic hdr_deq;

    req_fifo #(
        .DEPTH(HDR_FIFO_DEPTH),
        .THRESHOLD(TX_ALM_FULL_THRESHOLD)
    ) hdr_fifo (
        .clk(clk),
        .reset(reset),
        .enq_en(hdr_enq_en),
        .enq_data(hdr_enq),
        .deq_en(hdr_deq),
        .first(hdr_first),
        .not_empty(hdr_not_empty),
        .alm_full(hdr_alm_full)
    );

    c1_req_t stg1;
    c1_req_t stg2;
    c1_req_t stg3;
    logic stg1_sop;
    cl_num_t stg1_beat_idx;
    cl_num_t stg1_beats_rem;
    heap_idx_t stg1_heap_idx;

    logic may_fire;
    logic stg1_done;
    logic stg1_flit_en;
    logic free_en;

    always_comb
    begin
        may_fire = !mem_c1_alm_full;

        // The packet in stage 1 finishes when its last beat fires
        stg1_done = may_fire && (stg1_beats_rem == '0);
        stg1_flit_en = may_fire && stg1.valid;
        free_en = stg1_done && stg1.valid;

        // Refill stage 1 when it is idle or about to drain
        hdr_deq = hdr_not_empty && (stg1_done || !stg1.valid);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stg1.valid <= 1'b0;
            stg1_sop <= 1'b1;
            stg1_beat_idx <= '0;
            stg1_beats_rem <= '0;
            stg2.valid <= 1'b0;
            stg3.valid <= 1'b0;
            heap_free <= 1'b0;
        end
        else
        begin
            // Stage 1 walks the beats of the current header
            if (hdr_deq)
            begin
                stg1 <= hdr_first;
                stg1_sop <= 1'b1;
                stg1_beat_idx <= '0;
                stg1_beats_rem <= hdr_first.cl_len;
                stg1_heap_idx <= hdr_first.data[HEAP_IDX_WIDTH-1:0];
            end
            else if (stg1_done)
            begin
                stg1.valid <= 1'b0;
            end
            else if (stg1_flit_en)
            begin
                stg1_sop <= 1'b0;
                stg1_beat_idx <= stg1_beat_idx + 1'b1;
                stg1_beats_rem <= stg1_beats_rem - 1'b1;
            end

            // Stage 2 marks sop on the first beat and folds the beat into the address
            if (may_fire)
            begin
                stg2 <= stg1;
                stg2.sop <= stg1_sop;
                stg2.addr[CL_NUM_WIDTH-1:0] <= stg1.addr[CL_NUM_WIDTH-1:0] | stg1_beat_idx;
            end
            else
            begin
                stg2.valid <= 1'b0;
            end

            // Beats past stage 1 keep moving under back-pressure
            stg3 <= stg2;

            heap_free <= free_en;
        end

        // The heap address travels with stage 2 so the data meets stage 3
        if (stg1_flit_en)
        begin
            heap_raddr <= {stg1_heap_idx, stg1_beat_idx};
        end

        if (free_en)
        begin
            heap_free_idx <= stg1_heap_idx;
        end
    end

    // Heap data joins the beat on its way out
    always_comb
    begin
        mem_c1_tx = stg3;
        mem_c1_tx.data = heap_rdata;
    end

    a_client_mdata: assert property (@(posedge clk) disable iff (reset)
        afu_c0_tx.valid |-> !afu_c0_tx.mdata[PT_MDATA_BIT])
        else $error("Client read uses reserved mdata bit %0d", PT_MDATA_BIT);

endmodule

//--- logic/mem_edge_top.sv
// Top level of the memory edge, joining the client ports, both edges, the heap and memory
`timescale 1ns/10ps

module mem_edge_top
    import mem_edge_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // Client side
    input  c0_req_t afu_c0_tx,
    output c0_rsp_t afu_c0_rx,
    output logic afu_c0_alm_full,
    input  c1_req_t afu_c1_tx,
    output logic afu_c1_alm_full,

    // Page-table walker
    input  logic pt_read_en,
    input  cl_addr_t pt_read_addr,
    output logic pt_read_rdy,
    output logic pt_rsp_en,
    output cl_data_t pt_rsp_data,

    // Memory side
    output c0_req_t mem_c0_tx,
    input  c0_rsp_t mem_c0_rx,
    input  logic mem_c0_alm_full,
    output c1_req_t mem_c1_tx,
    input  logic mem_c1_alm_full
);

    // Header path between the two edges
    logic hdr_enq_en;
    c1_req_t hdr_enq;
    logic hdr_alm_full;

    // Heap ports and slot release
    logic heap_wen;
    logic [HEAP_ADDR_WIDTH-1:0] heap_waddr;
    cl_data_t heap_wdata;
    logic [HEAP_ADDR_WIDTH-1:0] heap_raddr;
    cl_data_t heap_rdata;
    logic heap_free;
    heap_idx_t heap_free_idx;

    afu_write_edge afu_write_edge_inst (
        .clk(clk),
        .reset(reset),
        .afu_c1_tx(afu_c1_tx),
        .afu_c1_alm_full(afu_c1_alm_full),
        .hdr_alm_full(hdr_alm_full),
        .hdr_enq_en(hdr_enq_en),
        .hdr_enq(hdr_enq),
        .heap_wen(heap_wen),
        .heap_waddr(heap_waddr),
        .heap_wdata(heap_wdata),
        .heap_free(heap_free),
        .heap_free_idx(heap_free_idx)
    );

    write_heap_ram write_heap_ram_inst (
        .clk(clk),
        .wen(heap_wen),
        .waddr(heap_waddr),
        .wdata(heap_wdata),
        .raddr(heap_raddr),
        .rdata(heap_rdata)
    );

    fiu_edge fiu_edge_inst (
        .clk(clk),
        .reset(reset),
        .afu_c0_tx(afu_c0_tx),
        .afu_c0_rx(afu_c0_rx),
        .afu_c0_alm_full(afu_c0_alm_full),
        .pt_read_en(pt_read_en),
        .pt_read_addr(pt_read_addr),
        .pt_read_rdy(pt_read_rdy),
        .pt_rsp_en(pt_rsp_en),
        .pt_rsp_data(pt_rsp_data),
        .hdr_enq_en(hdr_enq_en),
        .hdr_enq(hdr_enq),
        .hdr_alm_full(hdr_alm_full),
        .heap_raddr(heap_raddr),
        .heap_rdata(heap_rdata),
        .heap_free(heap_free),
        .heap_free_idx(heap_free_idx),
        .mem_c0_tx(mem_c0_tx),
        .mem_c0_rx(mem_c0_rx),
        .mem_c0_alm_full(mem_c0_alm_full),
        .mem_c1_tx(mem_c1_tx),
        .mem_c1_alm_full(mem_c1_alm_full)
    );

endmodule

//--- verif/mem_edge_tb.sv
// Random testbench for the memory edge; plays client, walker and memory and checks every output
`timescale 1ns/10ps

module mem_edge_tb
    import mem_edge_pkg::*;
();

    // ========================================================================
    // Test sizes and limits
    // ========================================================================

    localparam int NUM_PACKETS = 300;
    localparam int NUM_READS = 400;
    localparam int NUM_WALKS = 40;

    // Roughly twenty cycles for each of the 740 operations, rounded up
    localparam int TIMEOUT_CYCLES = 20000;

    localparam mdata_t WALK_MDATA = mdata_t'(1) << PT_MDATA_BIT;

    logic clk = 1'b0;
    logic reset;

    c0_req_t afu_c0_tx;
    c0_rsp_t afu_c0_rx;
    logic afu_c0_alm_full;
    c1_req_t afu_c1_tx;
    logic afu_c1_alm_full;
    logic pt_read_en;
    cl_addr_t pt_read_addr;
    logic pt_read_rdy;
    logic pt_rsp_en;
    cl_data_t pt_rsp_data;
    c0_req_t mem_c0_tx;
    c0_rsp_t mem_c0_rx;
    logic mem_c0_alm_full;
    c1_req_t mem_c1_tx;
    logic mem_c1_alm_full;

    mem_edge_top mem_edge_top_inst (
        .clk(clk),
        .reset(reset),
        .afu_c0_tx(afu_c0_tx),
        .afu_c0_rx(afu_c0_rx),
        .afu_c0_alm_full(afu_c0_alm_full),
        .afu_c1_tx(afu_c1_tx),
        .afu_c1_alm_full(afu_c1_alm_full),
        .pt_read_en(pt_read_en),
        .pt_read_addr(pt_read_addr),
        .pt_read_rdy(pt_read_rdy),
        .pt_rsp_en(pt_rsp_en),
        .pt_rsp_data(pt_rsp_data),
        .mem_c0_tx(mem_c0_tx),
        .mem_c0_rx(mem_c0_rx),
        .mem_c0_alm_full(mem_c0_alm_full),
        .mem_c1_tx(mem_c1_tx),
        .mem_c1_alm_full(mem_c1_alm_full)
    );

    always
    begin
        #5 clk = ~clk;
    end

    // ========================================================================
    // Model state
    // ========================================================================

    // A memory read waiting for its turn on the response bus
    typedef struct packed {
        logic [31:0] due;
        cl_addr_t addr;
        mdata_t mdata;
    } pend_rsp_t;

    integer seed;
    int cycle = 0;
    int errors;

    // Expected write beats in exit order, and reads the responder still owes
    c1_req_t beat_q[$];
    pend_rsp_t rsp_q[$];

    // Client read driven last cycle, due on mem_c0_tx now
    c0_req_t prev_rd;
    c0_rsp_t drv_rsp;

    // Walker read not yet on mem_c0_tx, and walker read not yet answered
    logic walk_issue_pend;
    logic walk_busy;
    cl_addr_t walk_addr;

    // Walker request driven last cycle, so the DUT has only just registered it
    logic walk_just_req;

    // Packet being sent by the client
    c1_req_t pkt_hdr;
    cl_num_t beat_num;
    int beats_left;

    int reads_sent;
    int walks_sent;
    int pkts_sent;
    int walks_seen;
    int client_rsps;
    int walk_rsps;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run hung and was stopped after %0d cycles", cycle);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // True with a chance of pct percent
    function automatic bit chance(input int pct);
        int r;
        r = $random(seed);
        return ((r & 32'h7fff_ffff) % 100) < pct;
    endfunction

    // The responder's data is a fixed mix of the read address
    function automatic cl_data_t rsp_data(input cl_addr_t addr);
        return {addr ^ 32'h5a5a_c3c3, addr};
    endfunction

    function automatic bit traffic_done();
        return reads_sent == NUM_READS && walks_sent == NUM_WALKS && pkts_sent == NUM_PACKETS
            && beats_left == 0 && beat_q.size() == 0 && rsp_q.size() == 0
            && !walk_busy && !prev_rd.valid;
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    // ========================================================================
    // Per-cycle checks and stimulus
    // ========================================================================

    // Registered outputs, sampled at the falling edge
    task automatic check_outputs();
        c1_req_t want;
        pend_rsp_t ent;
        logic [31:0] r;
        if (prev_rd.valid)
        begin
            if (mem_c0_tx !== prev_rd)
                log_error($sformatf("client read %h/%h left as valid %b addr %h mdata %h",
                    prev_rd.addr, prev_rd.mdata, mem_c0_tx.valid, mem_c0_tx.addr,
                    mem_c0_tx.mdata));
        end
        else if (mem_c0_tx.valid)
        begin
            // An empty client slot may only carry the pending walker read
            if (!walk_issue_pend || mem_c0_tx.addr !== walk_addr || mem_c0_tx.mdata !== WALK_MDATA)
                log_error($sformatf("unexpected read addr %h mdata %h on the memory port",
                    mem_c0_tx.addr, mem_c0_tx.mdata));
            walk_issue_pend = 1'b0;
            walks_seen++;
        end
        else if (walk_issue_pend && !walk_just_req)
        begin
            // A registered walker read takes the first slot the client leaves empty
            log_error($sformatf("walker read addr %h not issued in an empty read slot",
                walk_addr));
        end

        // Memory takes every read and answers it 1 to 8 cycles later
        if (mem_c0_tx.valid)
        begin
            r = rand32();
            ent.due = 32'(cycle) + 32'd1 + 32'(r[2:0]);
            ent.addr = mem_c0_tx.addr;
            ent.mdata = mem_c0_tx.mdata;
            rsp_q.push_back(ent);
        end

        if (mem_c1_tx.valid)
        begin
            if (beat_q.size() == 0)
                log_error($sformatf("write beat addr %h with none expected", mem_c1_tx.addr));
            else
            begin
                want = beat_q.pop_front();
                if (mem_c1_tx !== want)
                    log_error($sformatf("write beat sop %b addr %h len %0d data %h, want %b %h %0d %h",
                        mem_c1_tx.sop, mem_c1_tx.addr, mem_c1_tx.cl_len, mem_c1_tx.data,
                        want.sop, want.addr, want.cl_len, want.data));
            end
        end

        if (pt_read_rdy !== !walk_issue_pend)
            log_error($sformatf("pt_read_rdy is %b with walker read pending %b",
                pt_read_rdy, walk_issue_pend));
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        c1_req_t want;
        int pick;
        afu_c0_tx = '0;
        if (reads_sent < NUM_READS && chance(50))
        begin
            r = rand32();
            afu_c0_tx.valid = 1'b1;
            afu_c0_tx.addr = rand32();
            afu_c0_tx.mdata = r[MDATA_WIDTH-1:0];
            afu_c0_tx.mdata[PT_MDATA_BIT] = 1'b0;
            reads_sent++;
        end
        prev_rd = afu_c0_tx;

        // One walker read at a time, from request to response
        pt_read_en = 1'b0;
        if (walks_sent < NUM_WALKS && !walk_busy && pt_read_rdy && chance(25))
        begin
            pt_read_en = 1'b1;
            pt_read_addr = rand32();
            walk_addr = pt_read_addr;
            walk_issue_pend = 1'b1;
            walk_busy = 1'b1;
            walks_sent++;
        end
        walk_just_req = pt_read_en;

        // A packet starts only while the write side has room, then runs back to back
        afu_c1_tx = '0;
        if (beats_left == 0 && pkts_sent < NUM_PACKETS && !afu_c1_alm_full && chance(60))
        begin
            r = rand32();
            pkt_hdr = '0;
            pkt_hdr.valid = 1'b1;
            pkt_hdr.addr = rand32();
            pkt_hdr.cl_len = r[CL_NUM_WIDTH-1:0];
            pkt_hdr.mdata = r[31:16];
            beat_num = '0;
            beats_left = int'(pkt_hdr.cl_len) + 1;
            pkts_sent++;
        end
        if (beats_left > 0)
        begin
            afu_c1_tx = pkt_hdr;
            afu_c1_tx.sop = (beat_num == '0);
            afu_c1_tx.data = {rand32(), rand32()};
            // Beat k leaves with k in the low address bits and its own data
            want = afu_c1_tx;
            want.addr[CL_NUM_WIDTH-1:0] = pkt_hdr.addr[CL_NUM_WIDTH-1:0] | beat_num;
            beat_q.push_back(want);
            beat_num = beat_num + 1'b1;
            beats_left--;
        end

        mem_c1_alm_full = chance(20);

        // Read-side almost full is only passed back to the client
        mem_c0_alm_full = chance(20);

        // Oldest response that is due goes out this cycle
        drv_rsp = '0;
        pick = -1;
        for (int i = 0; i < rsp_q.size(); i++)
        begin
            if (pick < 0 && rsp_q[i].due <= 32'(cycle))
                pick = i;
        end
        if (pick >= 0)
        begin
            drv_rsp.valid = 1'b1;
            drv_rsp.mdata = rsp_q[pick].mdata;
            drv_rsp.data = rsp_data(rsp_q[pick].addr);
            rsp_q.delete(pick);
        end
        mem_c0_rx = drv_rsp;
    endtask

    // Response steering is combinational, so it is checked just after the drive
    task automatic check_responses();
        if (drv_rsp.valid && drv_rsp.mdata[PT_MDATA_BIT])
        begin
            if (pt_rsp_en !== 1'b1 || pt_rsp_data !== drv_rsp.data || afu_c0_rx.valid !== 1'b0)
                log_error($sformatf("walker response data %h seen as pt %b %h, client valid %b",
                    drv_rsp.data, pt_rsp_en, pt_rsp_data, afu_c0_rx.valid));
            walk_rsps++;
            walk_busy = 1'b0;
        end
        else if (drv_rsp.valid)
        begin
            if (afu_c0_rx !== drv_rsp || pt_rsp_en !== 1'b0)
                log_error($sformatf("client response mdata %h seen as %b %h %h, pt %b",
                    drv_rsp.mdata, afu_c0_rx.valid, afu_c0_rx.mdata, afu_c0_rx.data, pt_rsp_en));
            client_rsps++;
        end
        else if (afu_c0_rx.valid !== 1'b0 || pt_rsp_en !== 1'b0)
            log_error("response raised with none from memory");

        if (afu_c0_alm_full !== mem_c0_alm_full)
            log_error($sformatf("afu_c0_alm_full is %b with memory read almost full %b",
                afu_c0_alm_full, mem_c0_alm_full));
    endtask

    task automatic run_cycle();
        @(negedge clk);
        check_outputs();
        drive_inputs();
        #1;
        check_responses();
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial
    begin
        seed = 32'hc3f0_e53b;
        errors = 0;
        reset = 1'b1;
        afu_c0_tx = '0;
        afu_c1_tx = '0;
        pt_read_en = 1'b0;
        pt_read_addr = '0;
        mem_c0_rx = '0;
        mem_c0_alm_full = 1'b0;
        mem_c1_alm_full = 1'b0;
        prev_rd = '0;
        drv_rsp = '0;
        walk_issue_pend = 1'b0;
        walk_busy = 1'b0;
        walk_addr = '0;
        walk_just_req = 1'b0;
        pkt_hdr = '0;
        beat_num = '0;
        beats_left = 0;
        reads_sent = 0;
        walks_sent = 0;
        pkts_sent = 0;
        walks_seen = 0;
        client_rsps = 0;
        walk_rsps = 0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (mem_c0_tx.valid !== 1'b0 || mem_c1_tx.valid !== 1'b0 || pt_rsp_en !== 1'b0
            || pt_read_rdy !== 1'b1)
            log_error("outputs not idle after reset");

        while (!traffic_done())
        begin
            run_cycle();
        end

        // A few idle cycles let the last heap slots come back
        repeat (4) run_cycle();

        if (afu_c1_alm_full !== 1'b0)
            log_error("write side still almost full after all traffic drained");
        if (client_rsps != NUM_READS)
            log_error($sformatf("%0d client responses, want %0d", client_rsps, NUM_READS));
        if (walk_rsps != NUM_WALKS || walks_seen != NUM_WALKS)
            log_error($sformatf("%0d walker reads and %0d responses, want %0d",
                walks_seen, walk_rsps, NUM_WALKS));

        $display("Finished %0d packets, %0d reads, %0d walker reads with %0d errors",
            pkts_sent, reads_sent, walks_sent, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- flist.f
logic/mem_edge_pkg.sv
logic/write_heap_ram.sv
logic/req_fifo.sv
logic/afu_write_edge.sv
logic/fiu_edge.sv
logic/mem_edge_top.sv
verif/mem_edge_tb.sv

//--- Makefile
# Verilator build and run for the memory edge testbench

VERILATOR ?= verilator
TOP       ?= mem_edge_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The run fails unless the pass message shows up on a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)
